// File: common/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W 4

// RAM geometry, 4096 words
`define RAM_ADDR_W 12
// Byte offset below the word index
`define RAM_ALIGN 2

// Address map
`define CHIP_SEL_BIT 20
`define BLOCK_SEL_LO 17
`define BLOCK_SEL_HI 19

`endif

// File: common/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // Address bit 20 picks the on-chip blocks or the Wishbone side
  typedef enum logic {
    INTERNAL = 1'b0,
    EXTERNAL = 1'b1
  } chip_sel_e;

  // Internal block field, only DRAM and IRAM are mapped
  typedef enum logic [2:0] {
    DRAM       = 3'd0,
    IRAM       = 3'd1,
    BLK_RSVD_2 = 3'd2,
    BLK_RSVD_3 = 3'd3,
    BLK_RSVD_4 = 3'd4,
    BLK_RSVD_5 = 3'd5,
    BLK_RSVD_6 = 3'd6,
    BLK_RSVD_7 = 3'd7
  } block_sel_e;

  // Which requester holds the unified bus
  typedef enum logic [1:0] {
    OWN_NONE  = 2'd0,
    OWN_INSTR = 2'd1,
    OWN_DATA  = 2'd2
  } owner_e;

  // OBI to Wishbone bridge FSM
  typedef enum logic [1:0] {
    WB_IDLE  = 2'd0,
    WB_CYCLE = 2'd1,
    WB_RESP  = 2'd2
  } wb_state_e;

endpackage

`default_nettype wire

// File: src/sram_byte_en.sv
`timescale 1ns/1ps
`default_nettype none

module sram_byte_en #(
  parameter int ADDR_W = 12,
  parameter int DATA_W = 32
) (
  input  wire logic                clk_i,
  input  wire logic [ADDR_W-1:0]   addr_i,
  input  wire logic                we_i,
  input  wire logic [DATA_W/8-1:0] be_i,
  input  wire logic [DATA_W-1:0]   wdata_i,
  output logic      [DATA_W-1:0]   rdata_o
);

  localparam int NUM_BYTES = DATA_W / 8;

  // Word array, contents undefined at power up
  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk_i) begin
    // Only enabled byte lanes are written
    for (int i = 0; i < NUM_BYTES; i++) begin
      if (we_i && be_i[i]) begin
        mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
      end
    end
    // Registered read, old word on a write
    rdata_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

// File: arbiter/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module bus_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Instruction requester
  input  wire logic                   instr_req_i,
  input  wire logic [`SOC_ADDR_W-1:0] instr_addr_i,
  output logic                        instr_gnt_o,
  output logic                        instr_rvalid_o,
  output logic      [`SOC_DATA_W-1:0] instr_rdata_o,
  // Data requester
  input  wire logic                   data_req_i,
  input  wire logic [`SOC_ADDR_W-1:0] data_addr_i,
  input  wire logic                   data_we_i,
  input  wire logic [`SOC_BE_W-1:0]   data_be_i,
  input  wire logic [`SOC_DATA_W-1:0] data_wdata_i,
  output logic                        data_gnt_o,
  output logic                        data_rvalid_o,
  output logic      [`SOC_DATA_W-1:0] data_rdata_o,
  // Unified bus
  output logic                        bus_req_o,
  output logic      [`SOC_ADDR_W-1:0] bus_addr_o,
  output logic                        bus_we_o,
  output logic      [`SOC_BE_W-1:0]   bus_be_o,
  output logic      [`SOC_DATA_W-1:0] bus_wdata_o,
  input  wire logic                   bus_gnt_i,
  input  wire logic                   bus_rvalid_i,
  input  wire logic [`SOC_DATA_W-1:0] bus_rdata_i
);

  soc_pkg::owner_e owner_q;
  soc_pkg::owner_e sel_own;
  logic            granted_q;

  // Locked owner wins, otherwise data before instruction
  always_comb begin
    if (owner_q != soc_pkg::OWN_NONE) begin
      sel_own = owner_q;
    end else if (data_req_i) begin
      sel_own = soc_pkg::OWN_DATA;
    end else if (instr_req_i) begin
      sel_own = soc_pkg::OWN_INSTR;
    end else begin
      sel_own = soc_pkg::OWN_NONE;
    end
  end

  // Forward the chosen requester, nothing after its grant
  always_comb begin
    bus_req_o   = 1'b0;
    bus_addr_o  = instr_addr_i;
    bus_we_o    = 1'b0;
    bus_be_o    = '1;
    bus_wdata_o = '0;
    case (sel_own)
      soc_pkg::OWN_DATA: begin
        bus_req_o   = data_req_i && !granted_q;
        bus_addr_o  = data_addr_i;
        bus_we_o    = data_we_i;
        bus_be_o    = data_be_i;
        bus_wdata_o = data_wdata_i;
      end
      // Fetch path is read only
      soc_pkg::OWN_INSTR: begin
        bus_req_o = instr_req_i && !granted_q;
      end
      default: begin
        bus_req_o = 1'b0;
      end
    endcase
  end

  // Owner locked from first forward until rvalid
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q   <= soc_pkg::OWN_NONE;
      granted_q <= 1'b0;
    end else if (bus_rvalid_i) begin
      owner_q   <= soc_pkg::OWN_NONE;
      granted_q <= 1'b0;
    end else begin
      if (bus_req_o) begin
        owner_q <= sel_own;
      end
      if (bus_gnt_i) begin
        granted_q <= 1'b1;
      end
    end
  end

  // Responses steered back to the owner
  assign instr_gnt_o    = bus_gnt_i && (owner_q == soc_pkg::OWN_INSTR);
  assign data_gnt_o     = bus_gnt_i && (owner_q == soc_pkg::OWN_DATA);
  assign instr_rvalid_o = bus_rvalid_i && (owner_q == soc_pkg::OWN_INSTR);
  assign data_rvalid_o  = bus_rvalid_i && (owner_q == soc_pkg::OWN_DATA);
  assign instr_rdata_o  = bus_rdata_i;
  assign data_rdata_o   = bus_rdata_i;

  // Every bus grant lands on exactly one port
  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_gnt_i |-> (instr_gnt_o ^ data_gnt_o));

endmodule

`default_nettype wire

// File: src/bus_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module bus_router (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Unified bus
  input  wire logic                   bus_req_i,
  input  wire logic [`SOC_ADDR_W-1:0] bus_addr_i,
  input  wire logic                   bus_we_i,
  output logic                        bus_gnt_o,
  output logic                        bus_rvalid_o,
  output logic      [`SOC_DATA_W-1:0] bus_rdata_o,
  // RAMs
  output logic                        iram_we_o,
  output logic                        dram_we_o,
  input  wire logic [`SOC_DATA_W-1:0] iram_rdata_i,
  input  wire logic [`SOC_DATA_W-1:0] dram_rdata_i,
  // Bridge
  output logic                        ext_req_o,
  input  wire logic                   ext_gnt_i,
  input  wire logic                   ext_rvalid_i,
  input  wire logic [`SOC_DATA_W-1:0] ext_rdata_i
);

  soc_pkg::chip_sel_e  chip_sel;
  soc_pkg::block_sel_e block_sel;
  soc_pkg::chip_sel_e  chip_q;
  soc_pkg::block_sel_e block_sel_q;
  logic                pend_q;
  logic                int_gnt_q;
  logic                int_rvalid_q;
  logic                gnt_seen_q;

  assign chip_sel  = soc_pkg::chip_sel_e'(bus_addr_i[`CHIP_SEL_BIT]);
  assign block_sel = soc_pkg::block_sel_e'(bus_addr_i[`BLOCK_SEL_HI:`BLOCK_SEL_LO]);

  // Bridge only sees external transfers
  assign ext_req_o = bus_req_i && (chip_sel == soc_pkg::EXTERNAL);

  // Target captured on the first cycle of a request
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      chip_q      <= soc_pkg::INTERNAL;
      block_sel_q <= soc_pkg::DRAM;
    end else if (bus_rvalid_o) begin
      pend_q <= 1'b0;
    end else if (bus_req_i && !pend_q) begin
      pend_q      <= 1'b1;
      chip_q      <= chip_sel;
      block_sel_q <= block_sel;
    end
  end

  // Internal grant one cycle after req, rvalid one after that
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      int_gnt_q    <= 1'b0;
      int_rvalid_q <= 1'b0;
    end else begin
      int_gnt_q    <= bus_req_i && !pend_q && (chip_sel == soc_pkg::INTERNAL);
      int_rvalid_q <= int_gnt_q;
    end
  end

  // Handshake source by captured target
  assign bus_gnt_o    = (chip_q == soc_pkg::EXTERNAL) ? ext_gnt_i : int_gnt_q;
  assign bus_rvalid_o = (chip_q == soc_pkg::EXTERNAL) ? ext_rvalid_i : int_rvalid_q;

  // Writes land in the grant cycle, address still held
  assign dram_we_o = int_gnt_q && bus_we_i && (block_sel_q == soc_pkg::DRAM);
  assign iram_we_o = int_gnt_q && bus_we_i && (block_sel_q == soc_pkg::IRAM);

  // Unmapped blocks read as zero
  always_comb begin
    bus_rdata_o = '0;
    if (chip_q == soc_pkg::EXTERNAL) begin
      bus_rdata_o = ext_rdata_i;
    end else begin
      case (block_sel_q)
        soc_pkg::DRAM: bus_rdata_o = dram_rdata_i;
        soc_pkg::IRAM: bus_rdata_o = iram_rdata_i;
        default:       bus_rdata_o = '0;
      endcase
    end
  end

  // Grant seen since the last rvalid
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_seen_q <= 1'b0;
    end else if (bus_rvalid_o) begin
      gnt_seen_q <= 1'b0;
    end else if (bus_gnt_o) begin
      gnt_seen_q <= 1'b1;
    end
  end

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_o |-> gnt_seen_q);

endmodule

`default_nettype wire

// File: bridge/obi_wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module obi_wb_bridge (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // OBI side
  input  wire logic                   obi_req_i,
  input  wire logic [`SOC_ADDR_W-1:0] obi_addr_i,
  input  wire logic                   obi_we_i,
  input  wire logic [`SOC_BE_W-1:0]   obi_be_i,
  input  wire logic [`SOC_DATA_W-1:0] obi_wdata_i,
  output logic                        obi_gnt_o,
  output logic                        obi_rvalid_o,
  output logic      [`SOC_DATA_W-1:0] obi_rdata_o,
  // Wishbone master
  output logic      [`SOC_ADDR_W-1:0] wb_addr_o,
  output logic      [`SOC_DATA_W-1:0] wb_wdata_o,
  output logic                        wb_we_o,
  output logic      [`SOC_BE_W-1:0]   wb_sel_o,
  output logic                        wb_stb_o,
  output logic                        wb_cyc_o,
  input  wire logic [`SOC_DATA_W-1:0] wb_rdata_i,
  input  wire logic                   wb_ack_i
);

  soc_pkg::wb_state_e state_q;
  logic               rvalid_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= soc_pkg::WB_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      // rvalid trails the grant pulse by one cycle
      rvalid_q <= (state_q == soc_pkg::WB_RESP);
      case (state_q)
        soc_pkg::WB_IDLE: begin
          if (obi_req_i) begin
            state_q <= soc_pkg::WB_CYCLE;
          end
        end
        // Single-cycle ack ends the cycle
        soc_pkg::WB_CYCLE: begin
          if (wb_ack_i) begin
            state_q <= soc_pkg::WB_RESP;
          end
        end
        default: begin
          state_q <= soc_pkg::WB_IDLE;
        end
      endcase
    end
  end

  // Request captured on start, read data on ack
  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::WB_IDLE && obi_req_i) begin
      wb_addr_o  <= obi_addr_i;
      wb_wdata_o <= obi_wdata_i;
      wb_we_o    <= obi_we_i;
      wb_sel_o   <= obi_be_i;
    end
    if (state_q == soc_pkg::WB_CYCLE && wb_ack_i) begin
      obi_rdata_o <= wb_rdata_i;
    end
  end

  assign wb_cyc_o     = (state_q == soc_pkg::WB_CYCLE);
  assign wb_stb_o     = (state_q == soc_pkg::WB_CYCLE);
  assign obi_gnt_o    = (state_q == soc_pkg::WB_RESP);
  assign obi_rvalid_o = rvalid_q;

  // Ack only answers an open strobe inside the cycle
  a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |-> (wb_stb_o && wb_cyc_o));

endmodule

`default_nettype wire

// File: src/soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module soc_mem_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Instruction fetch port
  input  wire logic                   instr_req_i,
  input  wire logic [`SOC_ADDR_W-1:0] instr_addr_i,
  output logic                        instr_gnt_o,
  output logic                        instr_rvalid_o,
  output logic      [`SOC_DATA_W-1:0] instr_rdata_o,
  // Data port
  input  wire logic                   data_req_i,
  input  wire logic [`SOC_ADDR_W-1:0] data_addr_i,
  input  wire logic                   data_we_i,
  input  wire logic [`SOC_BE_W-1:0]   data_be_i,
  input  wire logic [`SOC_DATA_W-1:0] data_wdata_i,
  output logic                        data_gnt_o,
  output logic                        data_rvalid_o,
  output logic      [`SOC_DATA_W-1:0] data_rdata_o,
  // Wishbone master
  output logic      [`SOC_ADDR_W-1:0] wb_addr_o,
  output logic      [`SOC_DATA_W-1:0] wb_wdata_o,
  output logic                        wb_we_o,
  output logic      [`SOC_BE_W-1:0]   wb_sel_o,
  output logic                        wb_stb_o,
  output logic                        wb_cyc_o,
  input  wire logic [`SOC_DATA_W-1:0] wb_rdata_i,
  input  wire logic                   wb_ack_i
);

  // Unified bus
  logic                   bus_req;
  logic [`SOC_ADDR_W-1:0] bus_addr;
  logic                   bus_we;
  logic [`SOC_BE_W-1:0]   bus_be;
  logic [`SOC_DATA_W-1:0] bus_wdata;
  logic                   bus_gnt;
  logic                   bus_rvalid;
  logic [`SOC_DATA_W-1:0] bus_rdata;

  // RAM and bridge side
  logic [`RAM_ADDR_W-1:0] ram_addr;
  logic                   iram_we;
  logic                   dram_we;
  logic [`SOC_DATA_W-1:0] iram_rdata;
  logic [`SOC_DATA_W-1:0] dram_rdata;
  logic                   ext_req;
  logic                   ext_gnt;
  logic                   ext_rvalid;
  logic [`SOC_DATA_W-1:0] ext_rdata;

  // Word index above the byte offset
  assign ram_addr = bus_addr[`RAM_ALIGN +: `RAM_ADDR_W];

  bus_arbiter i_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_req_i     (data_req_i),
    .data_addr_i    (data_addr_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_wdata_i   (data_wdata_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .bus_req_o      (bus_req),
    .bus_addr_o     (bus_addr),
    .bus_we_o       (bus_we),
    .bus_be_o       (bus_be),
    .bus_wdata_o    (bus_wdata),
    .bus_gnt_i      (bus_gnt),
    .bus_rvalid_i   (bus_rvalid),
    .bus_rdata_i    (bus_rdata)
  );

  bus_router i_router (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req),
    .bus_addr_i   (bus_addr),
    .bus_we_i     (bus_we),
    .bus_gnt_o    (bus_gnt),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata),
    .iram_we_o    (iram_we),
    .dram_we_o    (dram_we),
    .iram_rdata_i (iram_rdata),
    .dram_rdata_i (dram_rdata),
    .ext_req_o    (ext_req),
    .ext_gnt_i    (ext_gnt),
    .ext_rvalid_i (ext_rvalid),
    .ext_rdata_i  (ext_rdata)
  );

  sram_byte_en #(
    .ADDR_W (`RAM_ADDR_W),
    .DATA_W (`SOC_DATA_W)
  ) i_iram (
    .clk_i   (clk_i),
    .addr_i  (ram_addr),
    .we_i    (iram_we),
    .be_i    (bus_be),
    .wdata_i (bus_wdata),
    .rdata_o (iram_rdata)
  );

  sram_byte_en #(
    .ADDR_W (`RAM_ADDR_W),
    .DATA_W (`SOC_DATA_W)
  ) i_dram (
    .clk_i   (clk_i),
    .addr_i  (ram_addr),
    .we_i    (dram_we),
    .be_i    (bus_be),
    .wdata_i (bus_wdata),
    .rdata_o (dram_rdata)
  );

  obi_wb_bridge i_bridge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .obi_req_i    (ext_req),
    .obi_addr_i   (bus_addr),
    .obi_we_i     (bus_we),
    .obi_be_i     (bus_be),
    .obi_wdata_i  (bus_wdata),
    .obi_gnt_o    (ext_gnt),
    .obi_rvalid_o (ext_rvalid),
    .obi_rdata_o  (ext_rdata),
    .wb_addr_o    (wb_addr_o),
    .wb_wdata_o   (wb_wdata_o),
    .wb_we_o      (wb_we_o),
    .wb_sel_o     (wb_sel_o),
    .wb_stb_o     (wb_stb_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_rdata_i   (wb_rdata_i),
    .wb_ack_i     (wb_ack_i)
  );

endmodule

`default_nettype wire

// File: bench/tb_soc_mem_checks.svh
`ifndef TB_SOC_MEM_CHECKS_SVH
`define TB_SOC_MEM_CHECKS_SVH

// Read data against the word from the vector file
task automatic check_rdata(input string name, input logic [`SOC_DATA_W-1:0] got,
                           input logic [`SOC_DATA_W-1:0] exp);
  if (got !== exp) begin
    $display("Error: time %0t: %s expected %h, got %h", $time, name, exp, got);
    fail_run();
  end
endtask

// Which requester the rvalid was steered to
task automatic check_owner(input soc_pkg::owner_e got, input soc_pkg::owner_e exp);
  if (got !== exp) begin
    $display("Error: time %0t: rvalid owner expected %s, got %s",
             $time, exp.name(), got.name());
    fail_run();
  end
endtask

// Single handshake or Wishbone bit
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Error: time %0t: %s expected %b, got %b", $time, name, exp, got);
    fail_run();
  end
endtask

`endif

// File: bench/tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_macros.svh"

module tb_soc_mem;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   instr_req_i;
  logic [`SOC_ADDR_W-1:0] instr_addr_i;
  logic                   instr_gnt_o;
  logic                   instr_rvalid_o;
  logic [`SOC_DATA_W-1:0] instr_rdata_o;
  logic                   data_req_i;
  logic [`SOC_ADDR_W-1:0] data_addr_i;
  logic                   data_we_i;
  logic [`SOC_BE_W-1:0]   data_be_i;
  logic [`SOC_DATA_W-1:0] data_wdata_i;
  logic                   data_gnt_o;
  logic                   data_rvalid_o;
  logic [`SOC_DATA_W-1:0] data_rdata_o;
  logic [`SOC_ADDR_W-1:0] wb_addr_o;
  logic [`SOC_DATA_W-1:0] wb_wdata_o;
  logic                   wb_we_o;
  logic [`SOC_BE_W-1:0]   wb_sel_o;
  logic                   wb_stb_o;
  logic                   wb_cyc_o;
  logic [`SOC_DATA_W-1:0] wb_rdata_i;
  logic                   wb_ack_i;

  // Vectors from the data file
  int                     t_port [64];
  int                     t_op [64];
  logic [`SOC_ADDR_W-1:0] t_addr [64];
  logic [`SOC_BE_W-1:0]   t_be [64];
  logic [`SOC_DATA_W-1:0] t_wdata [64];
  logic [`SOC_DATA_W-1:0] t_exp [64];
  int                     n_lines;

  int cycle_cnt = 0;
  int timeout_limit = 100000;
  int seed = 32'h3c6e;

  // Wishbone slave model state
  logic [`SOC_DATA_W-1:0] wb_mem [logic [`SOC_ADDR_W-1:0]];
  bit                     wb_active = 0;
  int                     wait_left;
  bit                     exp_wb_valid = 0;
  logic [`SOC_ADDR_W-1:0] exp_wb_addr;
  logic [`SOC_DATA_W-1:0] exp_wb_wdata;
  logic                   exp_wb_we;
  logic [`SOC_BE_W-1:0]   exp_wb_sel;

  soc_mem_top UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_req_i     (data_req_i),
    .data_addr_i    (data_addr_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_wdata_i   (data_wdata_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .wb_addr_o      (wb_addr_o),
    .wb_wdata_o     (wb_wdata_o),
    .wb_we_o        (wb_we_o),
    .wb_sel_o       (wb_sel_o),
    .wb_stb_o       (wb_stb_o),
    .wb_cyc_o       (wb_cyc_o),
    .wb_rdata_i     (wb_rdata_i),
    .wb_ack_i       (wb_ack_i)
  );

  task automatic fail_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_soc_mem_checks.svh"

  task automatic report_failure(input string msg);
    $display("Failure at time %0t: %s", $time, msg);
    fail_run();
  endtask

  always begin
    #4 clk_i = ~clk_i;
  end

  // Run limit counted in clock cycles
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Wishbone slave, random wait of 0 to 3 cycles before ack
  task automatic give_ack();
    logic [`SOC_DATA_W-1:0] word;
    word = wb_mem.exists(wb_addr_o) ? wb_mem[wb_addr_o] : '0;
    if (exp_wb_valid) begin
      check_rdata("wb_addr_o", wb_addr_o, exp_wb_addr);
      check_flag("wb_we_o", wb_we_o, exp_wb_we);
      check_flag("wb_sel_o[0]", wb_sel_o[0], exp_wb_sel[0]);
      check_flag("wb_sel_o[1]", wb_sel_o[1], exp_wb_sel[1]);
      check_flag("wb_sel_o[2]", wb_sel_o[2], exp_wb_sel[2]);
      check_flag("wb_sel_o[3]", wb_sel_o[3], exp_wb_sel[3]);
      if (exp_wb_we) begin
        check_rdata("wb_wdata_o", wb_wdata_o, exp_wb_wdata);
      end
    end
    if (wb_we_o) begin
      for (int b = 0; b < `SOC_BE_W; b++) begin
        if (wb_sel_o[b]) begin
          word[b*8 +: 8] = wb_wdata_o[b*8 +: 8];
        end
      end
      wb_mem[wb_addr_o] = word;
    end
    wb_rdata_i = word;
    wb_ack_i = 1'b1;
  endtask

  always @(negedge clk_i) begin
    if (wb_ack_i) begin
      // Ack lasts one cycle
      wb_ack_i = 1'b0;
      wb_active = 0;
    end else if (wb_active) begin
      check_flag("wb_cyc_o", wb_cyc_o, 1'b1);
      check_flag("wb_stb_o", wb_stb_o, 1'b1);
      if (wait_left == 0) begin
        give_ack();
      end else begin
        wait_left = wait_left - 1;
      end
    end else if (wb_cyc_o && wb_stb_o) begin
      wb_active = 1;
      wait_left = $random(seed) & 3;
      if (wait_left == 0) begin
        give_ack();
      end
    end
  end

  task automatic load_vectors();
    int                     fd;
    int                     code;
    int                     port;
    int                     op;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_DATA_W-1:0] exp;
    reg   [8*160-1:0]       line;
    n_lines = 0;
    fd = $fopen("bench/soc_mem_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open bench/soc_mem_testdata.txt");
    end
    while (!$feof(fd) && n_lines < 64) begin
      line = '0;
      code = $fgets(line, fd);
      if (code > 0) begin
        // Comment lines fail to parse and are skipped
        code = $sscanf(line, "%d %d %h %h %h %h", port, op, addr, be, wdata, exp);
        if (code == 6) begin
          t_port[n_lines]  = port;
          t_op[n_lines]    = op;
          t_addr[n_lines]  = addr;
          t_be[n_lines]    = be;
          t_wdata[n_lines] = wdata;
          t_exp[n_lines]   = exp;
          n_lines = n_lines + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // One transfer per used port, data issued first when both are used
  task automatic run_transfer(input bit use_d, input int di, input bit use_i, input int ii);
    int              cyc;
    bit              d_gnt;
    bit              i_gnt;
    bit              d_done;
    bit              i_done;
    bit              timed;
    int              k;
    soc_pkg::owner_e exp_own;
    soc_pkg::owner_e got_own;
    k = use_d ? di : ii;
    timed = !(use_d && use_i) && !t_addr[k][`CHIP_SEL_BIT];
    exp_wb_valid = !(use_d && use_i) && t_addr[k][`CHIP_SEL_BIT];
    exp_wb_addr  = t_addr[k];
    exp_wb_we    = use_d && (t_op[k] == 1);
    exp_wb_sel   = use_d ? t_be[k] : '1;
    exp_wb_wdata = t_wdata[k];
    if (use_d) begin
      data_req_i   = 1'b1;
      data_addr_i  = t_addr[di];
      data_we_i    = (t_op[di] == 1);
      data_be_i    = t_be[di];
      data_wdata_i = t_wdata[di];
    end
    if (use_i) begin
      instr_req_i  = 1'b1;
      instr_addr_i = t_addr[ii];
    end
    exp_own = use_d ? soc_pkg::OWN_DATA : soc_pkg::OWN_INSTR;
    d_gnt = 0;
    i_gnt = 0;
    d_done = !use_d;
    i_done = !use_i;
    cyc = 0;
    while (!(d_done && i_done)) begin
      @(negedge clk_i);
      cyc = cyc + 1;
      // Internal latency: grant after 1 cycle, rvalid after 2
      if (timed && cyc == 1) begin
        check_flag(use_d ? "data_gnt_o" : "instr_gnt_o",
                   use_d ? data_gnt_o : instr_gnt_o, 1'b1);
      end
      if (timed && cyc == 2) begin
        check_flag(use_d ? "data_rvalid_o" : "instr_rvalid_o",
                   use_d ? data_rvalid_o : instr_rvalid_o, 1'b1);
      end
      if (data_gnt_o) begin
        if (!use_d || d_gnt) begin
          report_failure("data port granted without an open request");
        end
        d_gnt = 1;
        data_req_i = 1'b0;
      end
      if (instr_gnt_o) begin
        if (!use_i || i_gnt) begin
          report_failure("instruction port granted without an open request");
        end
        if (!d_done) begin
          report_failure("instruction port granted before the data transfer finished");
        end
        i_gnt = 1;
        instr_req_i = 1'b0;
      end
      if (data_rvalid_o && instr_rvalid_o) begin
        report_failure("rvalid on both ports in the same cycle");
      end
      if (data_rvalid_o || instr_rvalid_o) begin
        got_own = data_rvalid_o ? soc_pkg::OWN_DATA : soc_pkg::OWN_INSTR;
        check_owner(got_own, exp_own);
        if (got_own == soc_pkg::OWN_DATA) begin
          if (!d_gnt) begin
            report_failure("data rvalid without a grant");
          end
          if (t_op[di] == 0) begin
            check_rdata("data_rdata_o", data_rdata_o, t_exp[di]);
          end
          d_done = 1;
          exp_own = soc_pkg::OWN_INSTR;
        end else begin
          if (!i_gnt) begin
            report_failure("instruction rvalid without a grant");
          end
          check_rdata("instr_rdata_o", instr_rdata_o, t_exp[ii]);
          i_done = 1;
        end
      end
    end
    data_we_i = 1'b0;
    exp_wb_valid = 0;
    // Idle cycle lets the owner lock clear
    @(negedge clk_i);
  endtask

  initial begin
    int idx;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_wdata_i = '0;
    wb_rdata_i   = '0;
    wb_ack_i     = 1'b0;
    load_vectors();
    timeout_limit = n_lines * 20 + 8;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("instr_gnt_o", instr_gnt_o, 1'b0);
    check_flag("instr_rvalid_o", instr_rvalid_o, 1'b0);
    check_flag("data_gnt_o", data_gnt_o, 1'b0);
    check_flag("data_rvalid_o", data_rvalid_o, 1'b0);
    check_flag("wb_cyc_o", wb_cyc_o, 1'b0);
    check_flag("wb_stb_o", wb_stb_o, 1'b0);
    idx = 0;
    while (idx < n_lines) begin
      if (t_port[idx] == 2) begin
        if (idx + 1 >= n_lines || t_port[idx + 1] != 0) begin
          report_failure("paired data line not followed by an instruction line");
        end
        run_transfer(1, idx, 1, idx + 1);
        idx = idx + 2;
      end else if (t_port[idx] == 1) begin
        run_transfer(1, idx, 0, 0);
        idx = idx + 1;
      end else begin
        run_transfer(0, 0, 1, idx);
        idx = idx + 1;
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/soc_mem_testdata.txt
# port: 0 instr, 1 data, 2 data paired with next instr line; op: 0 read, 1 write
# columns: port op addr be wdata expected_rdata (hex from addr on)
1 1 00000010 f 11223344 00000000
1 1 00000010 5 aabbccdd 00000000
1 0 00000010 f 00000000 11bb33dd
1 1 00020010 f 55667788 00000000
1 1 00020010 a cafe1234 00000000
0 0 00020010 f 00000000 ca661288
1 1 00100020 f deadbeef 00000000
1 1 00100024 3 0000a5a5 00000000
1 0 00100020 f 00000000 deadbeef
0 0 00100024 f 00000000 0000a5a5
1 1 00100020 c 12340000 00000000
1 0 00100020 f 00000000 1234beef
1 1 00000020 f 01020304 00000000
1 1 00020020 f 0a0b0c0d 00000000
2 0 00000020 f 00000000 01020304
0 0 00020020 f 00000000 0a0b0c0d
2 1 00000024 f 77777777 00000000
0 0 00000020 f 00000000 01020304
1 0 00000024 f 00000000 77777777
1 1 00040010 f ffffffff 00000000
1 0 00040010 f 00000000 00000000
1 0 00000010 f 00000000 11bb33dd
0 0 00020010 f 00000000 ca661288

// File: project.f
+incdir+common
+incdir+bench
common/soc_pkg.sv
src/sram_byte_en.sv
arbiter/bus_arbiter.sv
src/bus_router.sv
bridge/obi_wb_bridge.sv
src/soc_mem_top.sv
bench/tb_soc_mem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_mem \
  -f project.f -o sim_soc_mem
./obj_dir/sim_soc_mem > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
